/* src/ur_axi_pkg.sv */
package ur_axi_pkg;

    // ============================================================
    // widths
    // ============================================================
    localparam int DATA_WIDTH      = 128;
    localparam int ADDR_WIDTH      = 32;
    localparam int UR_ADDR_WIDTH   = 11;
    localparam int STRB_WIDTH      = DATA_WIDTH / 8;
    localparam int SLICE_CNT_WIDTH = 5;
    localparam int LEN_WIDTH       = 4;

    // ============================================================
    // AXI write side, fixed 16 byte beats in INCR bursts
    // ============================================================
    localparam logic [2:0] AXI_SIZE       = 3'b100;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    // one beat step, same on memory and user register side
    localparam int BEAT_BYTES = 1 << AXI_SIZE;

    // distance between neighbouring interleaved memory slices
    localparam int INTLV_STEP = 128;

    typedef logic [DATA_WIDTH-1:0]    data_t;
    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [UR_ADDR_WIDTH-1:0] ur_addr_t;
    typedef logic [STRB_WIDTH-1:0]    strb_t;
    typedef logic [LEN_WIDTH-1:0]     len_t;

    // micro instruction as latched by the sequencer
    typedef struct packed {
        logic [SLICE_CNT_WIDTH-1:0] slice_cnt;
        logic [3:0]                 byte_code;
        logic [1:0]                 brst_code;
        addr_t                      base_addr;
        ur_addr_t                   ur_addr;
    } micro_inst_t;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT,
        DONE
    } seq_state_t;

    // code 0 enables every lane, code k the lowest k lanes
    function automatic strb_t byte_mask(input logic [3:0] code);
        strb_t mask;
        for (int i = 0; i < STRB_WIDTH; i++) begin
            mask[i] = (code == 4'd0) || (i < int'(code));
        end
        return mask;
    endfunction

    // 0..3 -> 1, 2, 4, 8 beats
    function automatic len_t burst_beats(input logic [1:0] code);
        len_t beats;
        beats = len_t'(1) << code;
        return beats;
    endfunction

endpackage

/* src/beat_if.sv */
// one beat request from the sequencer, acceptance back from the writer
interface beat_if;

    logic                 req;
    ur_axi_pkg::addr_t    maddr;
    ur_axi_pkg::ur_addr_t ur_addr;
    ur_axi_pkg::strb_t    wstrb;
    ur_axi_pkg::len_t     mlen;

    // pulses once per req, after the AXI side took the beat
    logic                 accepted;

    modport seq (
        output req,
        output maddr,
        output ur_addr,
        output wstrb,
        output mlen,
        input  accepted
    );

    modport wr (
        input  req,
        input  maddr,
        input  ur_addr,
        input  wstrb,
        input  mlen,
        output accepted
    );

endinterface

/* src/conv_sequencer.sv */
module conv_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    i_inst_valid,
    input  ur_axi_pkg::micro_inst_t i_inst,

    beat_if.seq                     bif,

    output logic                    o_busy,
    output logic                    o_done
);

    ur_axi_pkg::seq_state_t                 state_q;
    ur_axi_pkg::seq_state_t                 state_d;
    ur_axi_pkg::micro_inst_t                inst_q;
    logic [ur_axi_pkg::SLICE_CNT_WIDTH-1:0] slice_q;
    ur_axi_pkg::len_t                       beat_q;
    ur_axi_pkg::len_t                       beats;
    logic                                   inst_take;
    logic                                   last_beat;
    logic                                   last_slice;
    logic                                   beat_out_q;
    ur_axi_pkg::addr_t                      slice_base;
    ur_axi_pkg::addr_t                      beat_maddr;
    ur_axi_pkg::ur_addr_t                   beat_ur_addr;

    // busy covers ISSUE and WAIT, so it drops together with done
    assign o_busy    = (state_q == ur_axi_pkg::ISSUE) || (state_q == ur_axi_pkg::WAIT);
    assign o_done    = (state_q == ur_axi_pkg::DONE);
    assign inst_take = i_inst_valid && !o_busy;

    // ============================================================
    // instruction latch and beat arithmetic
    // ============================================================
    always_ff @(posedge clk) begin
        if (inst_take) begin
            inst_q <= i_inst;
        end
    end

    assign beats      = ur_axi_pkg::burst_beats(inst_q.brst_code);
    assign last_beat  = (beat_q == beats - ur_axi_pkg::len_t'(1));
    assign last_slice = (slice_q == inst_q.slice_cnt);

    // slice start, then beat offset inside the slice
    assign slice_base = inst_q.base_addr
                      + ur_axi_pkg::addr_t'(slice_q) * ur_axi_pkg::addr_t'(ur_axi_pkg::INTLV_STEP);
    assign beat_maddr = slice_base
                      + ur_axi_pkg::addr_t'(beat_q) * ur_axi_pkg::addr_t'(ur_axi_pkg::BEAT_BYTES);

    // user register side restarts at ur_addr for every slice
    assign beat_ur_addr = inst_q.ur_addr
                        + ur_axi_pkg::ur_addr_t'(beat_q)
                        * ur_axi_pkg::ur_addr_t'(ur_axi_pkg::BEAT_BYTES);

    // ============================================================
    // state machine
    // ============================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ur_axi_pkg::IDLE,
            ur_axi_pkg::DONE: begin
                state_d = inst_take ? ur_axi_pkg::ISSUE : ur_axi_pkg::IDLE;
            end
            ur_axi_pkg::ISSUE: begin
                state_d = ur_axi_pkg::WAIT;
            end
            ur_axi_pkg::WAIT: begin
                if (bif.accepted) begin
                    if (last_beat && last_slice) begin
                        state_d = ur_axi_pkg::DONE;
                    end else begin
                        state_d = ur_axi_pkg::ISSUE;
                    end
                end
            end
            default: begin
                state_d = ur_axi_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ur_axi_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // beats first, then slices
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slice_q <= '0;
            beat_q  <= '0;
        end else if (inst_take) begin
            slice_q <= '0;
            beat_q  <= '0;
        end else if ((state_q == ur_axi_pkg::WAIT) && bif.accepted) begin
            if (last_beat) begin
                beat_q <= '0;
                if (!last_slice) begin
                    slice_q <= slice_q + 1'b1;
                end
            end else begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // ============================================================
    // beat request towards the writer
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bif.req     <= 1'b0;
            bif.maddr   <= '0;
            bif.ur_addr <= '0;
            bif.wstrb   <= '0;
            bif.mlen    <= '0;
        end else begin
            bif.req <= (state_q == ur_axi_pkg::ISSUE);
            if (state_q == ur_axi_pkg::ISSUE) begin
                bif.maddr   <= beat_maddr;
                bif.ur_addr <= beat_ur_addr;
                bif.wstrb   <= ur_axi_pkg::byte_mask(inst_q.byte_code);
                bif.mlen    <= beats - ur_axi_pkg::len_t'(1);
            end
        end
    end

    // beat handed to the writer and not yet accepted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_out_q <= 1'b0;
        end else if (bif.req) begin
            beat_out_q <= 1'b1;
        end else if (bif.accepted) begin
            beat_out_q <= 1'b0;
        end
    end

    a_req_not_outstanding: assert property (
        @(posedge clk) disable iff (!rst_n)
        bif.req |-> !beat_out_q
    ) else $error("beat request while a beat is outstanding");

    a_accept_has_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        bif.accepted |-> beat_out_q
    ) else $error("accepted without an outstanding beat");

    a_done_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        o_done |=> !o_done
    ) else $error("done high for two cycles");

endmodule

/* src/beat_writer.sv */
module beat_writer (
    input  logic                 clk,
    input  logic                 rst_n,

    beat_if.wr                   bif,

    // user register file, one cycle read latency
    input  ur_axi_pkg::data_t    i_ur_rdata,
    output logic                 o_ur_re,
    output ur_axi_pkg::ur_addr_t o_ur_addr,

    // AXI write side
    input  logic                 i_saccept,
    output logic                 o_mwrite,
    output ur_axi_pkg::addr_t    o_maddr,
    output ur_axi_pkg::len_t     o_mlen,
    output ur_axi_pkg::data_t    o_mdata,
    output ur_axi_pkg::strb_t    o_mwstrb
);

    // read data is on i_ur_rdata in this cycle
    logic rdata_vld_q;
    logic beat_take;

    assign beat_take = o_mwrite && i_saccept;

    // ============================================================
    // user register read
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_ur_re     <= 1'b0;
            o_ur_addr   <= '0;
            rdata_vld_q <= 1'b0;
        end else begin
            // single cycle read strobe per request
            o_ur_re     <= bif.req;
            rdata_vld_q <= o_ur_re;
            if (bif.req) begin
                o_ur_addr <= bif.ur_addr;
            end
        end
    end

    // ============================================================
    // beat fields
    // ============================================================
    // loaded while o_mwrite is still low, held until the next request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_maddr  <= '0;
            o_mwstrb <= '0;
            o_mlen   <= '0;
        end else if (bif.req) begin
            o_maddr  <= bif.maddr;
            o_mwstrb <= bif.wstrb;
            o_mlen   <= bif.mlen;
        end
    end

    // ============================================================
    // write hold until accept
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_mdata  <= '0;
            o_mwrite <= 1'b0;
        end else if (rdata_vld_q) begin
            // capture and present the beat in one step
            o_mdata  <= i_ur_rdata;
            o_mwrite <= 1'b1;
        end else if (beat_take) begin
            o_mwrite <= 1'b0;
        end
    end

    // one pulse per beat, right after the accepting edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bif.accepted <= 1'b0;
        end else begin
            bif.accepted <= beat_take;
        end
    end

    a_hold_until_accept: assert property (
        @(posedge clk) disable iff (!rst_n)
        (o_mwrite && !i_saccept) |=>
            (o_mwrite && $stable(o_maddr) && $stable(o_mdata))
    ) else $error("write beat changed before accept");

endmodule

/* src/ur_axi_conv.sv */
module ur_axi_conv (
    input  logic                                   clk,
    input  logic                                   rst_n,

    // micro instruction
    input  logic                                   i_inst_valid,
    input  logic [ur_axi_pkg::SLICE_CNT_WIDTH-1:0] i_slice_cnt,
    input  logic [3:0]                             i_byte_code,
    input  logic [1:0]                             i_brst_code,
    input  logic [ur_axi_pkg::ADDR_WIDTH-1:0]      i_base_addr,
    input  logic [ur_axi_pkg::UR_ADDR_WIDTH-1:0]   i_ur_addr,

    // user register file
    input  logic [ur_axi_pkg::DATA_WIDTH-1:0]      i_ur_rdata,
    output logic                                   o_ur_re,
    output logic [ur_axi_pkg::UR_ADDR_WIDTH-1:0]   o_ur_addr,

    // AXI write side
    input  logic                                   i_saccept,
    output logic                                   o_mwrite,
    output logic [ur_axi_pkg::ADDR_WIDTH-1:0]      o_maddr,
    output logic [ur_axi_pkg::LEN_WIDTH-1:0]       o_mlen,
    output logic [ur_axi_pkg::DATA_WIDTH-1:0]      o_mdata,
    output logic [ur_axi_pkg::STRB_WIDTH-1:0]      o_mwstrb,

    // status
    output logic                                   o_busy,
    output logic                                   o_done
);

    ur_axi_pkg::micro_inst_t inst;

    assign inst.slice_cnt = i_slice_cnt;
    assign inst.byte_code = i_byte_code;
    assign inst.brst_code = i_brst_code;
    assign inst.base_addr = i_base_addr;
    assign inst.ur_addr   = i_ur_addr;

    beat_if u_bif ();

    conv_sequencer u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_inst_valid (i_inst_valid),
        .i_inst       (inst),
        .bif          (u_bif.seq),
        .o_busy       (o_busy),
        .o_done       (o_done)
    );

    beat_writer u_wr (
        .clk        (clk),
        .rst_n      (rst_n),
        .bif        (u_bif.wr),
        .i_ur_rdata (i_ur_rdata),
        .o_ur_re    (o_ur_re),
        .o_ur_addr  (o_ur_addr),
        .i_saccept  (i_saccept),
        .o_mwrite   (o_mwrite),
        .o_maddr    (o_maddr),
        .o_mlen     (o_mlen),
        .o_mdata    (o_mdata),
        .o_mwstrb   (o_mwstrb)
    );

endmodule

/* tb/tb_ur_axi_conv.sv */
module tb_ur_axi_conv;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SLICE_STEP    = 128;
    localparam int BEAT_STEP     = 16;
    localparam int BEAT_TIMEOUT  = 200;
    localparam int DONE_TIMEOUT  = 50;
    localparam int NUM_ENTRIES   = 6;

    typedef struct packed {
        logic [4:0]  slice_cnt;
        logic [3:0]  byte_code;
        logic [1:0]  brst_code;
        logic [31:0] base_addr;
        logic [10:0] ur_addr;
    } inst_entry_t;

    // slice count, byte code, burst code, memory base, user register address
    localparam inst_entry_t INST_TABLE [NUM_ENTRIES] = '{
        '{5'd0,  4'd0,  2'd0, 32'h0000_1000, 11'h000},
        '{5'd1,  4'd1,  2'd1, 32'h8000_0040, 11'h120},
        '{5'd3,  4'd7,  2'd2, 32'h1234_5670, 11'h7f0},
        '{5'd31, 4'd15, 2'd3, 32'hffff_f800, 11'h400},
        '{5'd2,  4'd0,  2'd3, 32'h0000_0000, 11'h010},
        '{5'd31, 4'd7,  2'd0, 32'h4000_0000, 11'h7ff}
    };

    logic         clk = 1'b0;
    logic         rst_n;
    logic         i_inst_valid;
    logic [4:0]   i_slice_cnt;
    logic [3:0]   i_byte_code;
    logic [1:0]   i_brst_code;
    logic [31:0]  i_base_addr;
    logic [10:0]  i_ur_addr;
    logic [127:0] i_ur_rdata = '0;
    logic         i_saccept = 1'b0;
    logic         o_ur_re;
    logic [10:0]  o_ur_addr;
    logic         o_mwrite;
    logic [31:0]  o_maddr;
    logic [3:0]   o_mlen;
    logic [127:0] o_mdata;
    logic [15:0]  o_mwstrb;
    logic         o_busy;
    logic         o_done;

    // expected beats of the running instruction, oldest first
    logic [31:0]  exp_maddr_q [$];
    logic [10:0]  exp_ur_q [$];
    logic [127:0] exp_data_q [$];
    logic [15:0]  cur_strb;
    logic [3:0]   cur_len;

    int error_count = 0;
    int check_count = 0;
    int accept_count = 0;
    int done_count = 0;
    logic timeout_hit = 1'b0;

    // monitor state for the back-pressure check
    logic         hold_q = 1'b0;
    logic [31:0]  hold_maddr;
    logic [127:0] hold_mdata;
    logic [15:0]  hold_strb;
    logic         rd_pending;
    logic [10:0]  rd_addr;

    ur_axi_conv dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_inst_valid (i_inst_valid),
        .i_slice_cnt  (i_slice_cnt),
        .i_byte_code  (i_byte_code),
        .i_brst_code  (i_brst_code),
        .i_base_addr  (i_base_addr),
        .i_ur_addr    (i_ur_addr),
        .i_ur_rdata   (i_ur_rdata),
        .o_ur_re      (o_ur_re),
        .o_ur_addr    (o_ur_addr),
        .i_saccept    (i_saccept),
        .o_mwrite     (o_mwrite),
        .o_maddr      (o_maddr),
        .o_mlen       (o_mlen),
        .o_mdata      (o_mdata),
        .o_mwstrb     (o_mwstrb),
        .o_busy       (o_busy),
        .o_done       (o_done)
    );

    always #2 clk = ~clk;

    // ============================================================
    // helpers
    // ============================================================
    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error: t=%0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // odd multiplier keeps every address bit in every word
    function automatic logic [127:0] ur_model_word(input logic [10:0] addr);
        logic [127:0] word;
        logic [31:0]  a;
        a = {21'h0, addr};
        for (int i = 0; i < 4; i++) begin
            word[32*i +: 32] = ((a + 32'(i)) * 32'h9e37_79b1) ^ 32'hc3a5_0f00;
        end
        return word;
    endfunction

    function automatic logic [15:0] expected_strobe(input logic [3:0] code);
        if (code == 4'd0) begin
            return 16'hffff;
        end
        return (16'd1 << code) - 16'd1;
    endfunction

    task automatic await_beat(input int target);
        int cycles;
        cycles = 0;
        while (accept_count < target && cycles < BEAT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (accept_count < target) begin
            $display("timeout: beat %0d not accepted within %0d cycles", target, BEAT_TIMEOUT);
            error_count++;
            timeout_hit = 1'b1;
        end
    endtask

    task automatic catch_done(input int target);
        int cycles;
        cycles = 0;
        while (done_count < target && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (done_count < target) begin
            $display("timeout: done pulse missing after the last beat");
            error_count++;
            timeout_hit = 1'b1;
        end
    endtask

    // ============================================================
    // user register model and random accept
    // ============================================================
    initial begin
        void'($urandom(62134));
        forever begin
            @(posedge clk);
            rd_pending = o_ur_re;
            rd_addr    = o_ur_addr;
            #1;
            i_saccept = 1'($urandom_range(0, 1));
            // garbage outside the read slot
            if (rd_pending) begin
                i_ur_rdata = ur_model_word(rd_addr);
            end else begin
                i_ur_rdata = {$urandom(), $urandom(), $urandom(), $urandom()};
            end
        end
    end

    // ============================================================
    // monitor
    // ============================================================
    always @(posedge clk) begin
        if (!rst_n) begin
            hold_q = 1'b0;
        end else begin
            if (hold_q) begin
                check_value("o_mwrite", o_mwrite, 1'b1);
                check_value("o_maddr", o_maddr, hold_maddr);
                check_value("o_mdata", o_mdata, hold_mdata);
                check_value("o_mwstrb", o_mwstrb, hold_strb);
            end
            if (o_ur_re) begin
                if (o_mwrite) begin
                    error_count++;
                    $display("user register read issued while a beat was held at t=%0t", $time);
                end
                if (exp_ur_q.size() == 0) begin
                    error_count++;
                    $display("unexpected user register read at t=%0t", $time);
                end else begin
                    check_value("o_ur_addr", o_ur_addr, exp_ur_q.pop_front());
                end
            end
            if (o_mwrite && i_saccept) begin
                accept_count++;
                if (exp_maddr_q.size() == 0) begin
                    error_count++;
                    $display("unexpected write beat accepted at t=%0t", $time);
                end else begin
                    check_value("o_maddr", o_maddr, exp_maddr_q.pop_front());
                    check_value("o_mdata", o_mdata, exp_data_q.pop_front());
                    check_value("o_mwstrb", o_mwstrb, cur_strb);
                    check_value("o_mlen", o_mlen, cur_len);
                end
            end
            if (o_done) begin
                done_count++;
                if (exp_maddr_q.size() != 0) begin
                    error_count++;
                    $display("done pulsed with %0d beats still missing", exp_maddr_q.size());
                end
            end
            hold_q     = o_mwrite && !i_saccept;
            hold_maddr = o_maddr;
            hold_mdata = o_mdata;
            hold_strb  = o_mwstrb;
        end
    end

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        inst_entry_t ent;
        int beats;
        int total;
        int accept_base;
        logic [10:0] uaddr;

        rst_n        = 1'b0;
        i_inst_valid = 1'b0;
        i_slice_cnt  = '0;
        i_byte_code  = '0;
        i_brst_code  = '0;
        i_base_addr  = '0;
        i_ur_addr    = '0;
        cur_strb     = '0;
        cur_len      = '0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("o_mwrite", o_mwrite, 1'b0);
        check_value("o_ur_re", o_ur_re, 1'b0);
        check_value("o_busy", o_busy, 1'b0);
        check_value("o_done", o_done, 1'b0);
        check_value("o_maddr", o_maddr, '0);
        check_value("o_mdata", o_mdata, '0);
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int idx = 0; idx < NUM_ENTRIES; idx++) begin
            ent   = INST_TABLE[idx];
            beats = 1 << ent.brst_code;
            total = (int'(ent.slice_cnt) + 1) * beats;
            for (int s = 0; s <= int'(ent.slice_cnt); s++) begin
                for (int b = 0; b < beats; b++) begin
                    uaddr = ent.ur_addr + 11'(b * BEAT_STEP);
                    exp_maddr_q.push_back(ent.base_addr + 32'(s * SLICE_STEP + b * BEAT_STEP));
                    exp_ur_q.push_back(uaddr);
                    exp_data_q.push_back(ur_model_word(uaddr));
                end
            end
            cur_strb    = expected_strobe(ent.byte_code);
            cur_len     = 4'(beats - 1);
            accept_base = accept_count;

            @(posedge clk);
            #1;
            i_slice_cnt  = ent.slice_cnt;
            i_byte_code  = ent.byte_code;
            i_brst_code  = ent.brst_code;
            i_base_addr  = ent.base_addr;
            i_ur_addr    = ent.ur_addr;
            i_inst_valid = 1'b1;
            @(posedge clk);
            #1;
            i_inst_valid = 1'b0;
            @(posedge clk);
            check_value("o_busy", o_busy, 1'b1);

            // second instruction while busy, must be dropped
            #1;
            i_slice_cnt  = 5'd7;
            i_brst_code  = 2'd3;
            i_base_addr  = 32'hdead_0000;
            i_ur_addr    = 11'h555;
            i_inst_valid = 1'b1;
            @(posedge clk);
            #1;
            i_inst_valid = 1'b0;

            for (int n = 1; n <= total; n++) begin
                await_beat(accept_base + n);
                if (timeout_hit) begin
                    break;
                end
            end
            if (timeout_hit) begin
                break;
            end
            catch_done(idx + 1);
            if (timeout_hit) begin
                break;
            end
            #1;
            check_value("accepted beats", 128'(accept_count - accept_base), 128'(total));
            check_value("done pulses", 128'(done_count), 128'(idx + 1));
            check_value("o_busy", o_busy, 1'b0);
        end

        // idle tail, catches stray beats or done pulses
        repeat (20) @(posedge clk);
        #1;
        check_value("done pulses", 128'(done_count), 128'(NUM_ENTRIES));
        check_value("o_mwrite", o_mwrite, 1'b0);

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* flist.f */
src/ur_axi_pkg.sv
src/beat_if.sv
src/conv_sequencer.sv
src/beat_writer.sv
src/ur_axi_conv.sv
tb/tb_ur_axi_conv.sv

/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= tb_ur_axi_conv
RTL_TOP   ?= ur_axi_conv
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
FAIL_MSG  ?= sim failed
PASS_MSG  ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
